/* common/key_defs.svh */
`ifndef KEY_DEFS_SVH
`define KEY_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key count and index width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define KEY_NUM                 8
`define KEY_ID_W                3

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debounce timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define KEY_CLK_PRD_NS          10
`define KEY_LOW_THRESHOLD_NS    200     // 20 cycles at 10 ns
`define KEY_HIGH_THRESHOLD_NS   300     // 30 cycles at 10 ns

// released level, keys are active low
`define KEY_RST_LEVEL           1'b1

// event queue
`define KEY_FIFO_DEPTH          4

`endif

/* common/key_event_pkg.sv */
`default_nettype none
`include "key_defs.svh"

package key_event_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // key events as seen by the consumer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // encoding matches the debounced line level
    typedef enum logic {
        key_press   = 1'b0,     // line went low
        key_release = 1'b1      // line went high
    } key_kind_e;

    // four bits in all
    typedef struct packed {
        key_kind_e             kind;
        logic [`KEY_ID_W-1:0]  key_id;
    } key_event_t;

endpackage

`default_nettype wire

/* common/key_ctrl_pkg.sv */
`default_nettype none

package key_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // debounce filter control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        deb_stable   = 1'b0,    // output matches input, counter saturated
        deb_settling = 1'b1     // input changed, waiting for threshold
    } deb_state_e;

endpackage

`default_nettype wire

/* verilog/key_sync.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_sync (
    input  logic               clk,
    input  logic               rst,
    input  logic [`KEY_NUM-1:0] key_raw,
    output logic [`KEY_NUM-1:0] key_sync_q
);

    logic [`KEY_NUM-1:0] sync_meta;     // first stage, may go metastable

    // both stages start released so reset gives no edge downstream
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_meta  <= {`KEY_NUM{`KEY_RST_LEVEL}};
            key_sync_q <= {`KEY_NUM{`KEY_RST_LEVEL}};
        end else begin
            sync_meta  <= key_raw;
            key_sync_q <= sync_meta;
        end
    end

endmodule

`default_nettype wire

/* debounce/key_debounce.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_debounce #(
    parameter int LOW_CYCLES  = `KEY_LOW_THRESHOLD_NS / `KEY_CLK_PRD_NS,
    parameter int HIGH_CYCLES = `KEY_HIGH_THRESHOLD_NS / `KEY_CLK_PRD_NS
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic key_in,
    output logic key_out
);

    localparam int MAX_CYCLES = (LOW_CYCLES > HIGH_CYCLES) ? LOW_CYCLES : HIGH_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 2);  // room for cnt + 1 at the limit

    logic                     key_prev;
    logic                     key_out_r;
    logic                     key_chg;
    logic [CNT_W-1:0]         cnt;
    logic [CNT_W-1:0]         cnt_nxt;
    logic [CNT_W-1:0]         cnt_lim;
    key_ctrl_pkg::deb_state_e state;

    assign key_chg = key_in ^ key_prev;
    assign cnt_nxt = cnt + 1'b1;
    assign cnt_lim = key_in ? CNT_W'(HIGH_CYCLES) : CNT_W'(LOW_CYCLES);  // per-level limit

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // settle counter and level commit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            key_prev  <= `KEY_RST_LEVEL;
            key_out_r <= `KEY_RST_LEVEL;
            cnt       <= '0;
            state     <= key_ctrl_pkg::deb_stable;
        end else begin
            key_prev <= key_in;
            case (state)
                key_ctrl_pkg::deb_stable: begin
                    if (key_chg) begin
                        cnt   <= '0;                            // restart on any edge
                        state <= key_ctrl_pkg::deb_settling;
                    end
                end
                key_ctrl_pkg::deb_settling: begin
                    if (key_chg) begin
                        cnt <= '0;                              // bounce, start over
                    end else if (cnt_nxt >= cnt_lim) begin
                        cnt       <= cnt_nxt;                   // saturate at limit
                        key_out_r <= key_in;
                        state     <= key_ctrl_pkg::deb_stable;
                    end else begin
                        cnt <= cnt_nxt;
                    end
                end
                default: state <= key_ctrl_pkg::deb_stable;
            endcase
        end
    end

    // filter keeps running while bypassed so it is in step when en returns
    assign key_out = en ? key_out_r : key_in;

endmodule

`default_nettype wire

/* verilog/key_event_gen.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_event_gen (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`KEY_NUM-1:0]       key_level,
    output key_event_pkg::key_event_t evt_in,
    output logic                      evt_in_valid,
    input  logic                      evt_in_ready,
    output logic                      overflow
);

    logic [`KEY_NUM-1:0]  level_prev;
    logic [`KEY_NUM-1:0]  pending;
    logic [`KEY_NUM-1:0]  level_chg;
    logic [`KEY_NUM-1:0]  acc_mask;
    logic [`KEY_ID_W-1:0] low_id;
    logic [`KEY_ID_W-1:0] sel_id;
    logic [`KEY_ID_W-1:0] hold_id;
    logic                 hold_q;
    logic                 evt_acc;

    assign level_chg = key_level ^ level_prev;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pick lowest pending key
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        low_id = '0;
        for (int i = `KEY_NUM - 1; i >= 0; i--) begin
            if (pending[i]) begin
                low_id = `KEY_ID_W'(i);     // last hit wins, so lowest index
            end
        end
    end

    assign sel_id       = hold_q ? hold_id : low_id;    // keep a stalled offer
    assign evt_in_valid = |pending;
    assign evt_in.key_id = sel_id;
    assign evt_in.kind   = key_event_pkg::key_kind_e'(key_level[sel_id]);
    assign evt_acc      = evt_in_valid & evt_in_ready;
    assign acc_mask     = evt_acc ? (`KEY_NUM'(1) << sel_id) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            level_prev <= {`KEY_NUM{`KEY_RST_LEVEL}};
            pending    <= '0;
            hold_q     <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            level_prev <= key_level;
            pending    <= (pending & ~acc_mask) | level_chg;
            hold_q     <= evt_in_valid & ~evt_in_ready;
            // a second change before the first was taken loses an event
            if (|(level_chg & pending & ~acc_mask)) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_id <= sel_id;
    end

endmodule

`default_nettype wire

/* verilog/key_event_fifo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_event_fifo (
    input  logic                      clk,
    input  logic                      rst,
    input  key_event_pkg::key_event_t in_evt,
    input  logic                      in_valid,
    output logic                      in_ready,
    output key_event_pkg::key_event_t out_evt,
    output logic                      out_valid,
    input  logic                      out_ready
);

    localparam int DEPTH = `KEY_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    key_event_pkg::key_event_t mem [DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      do_wr;
    logic                      do_rd;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_evt   = mem[rd_ptr];
    assign do_wr     = in_valid & in_ready;
    assign do_rd     = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= in_evt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end                                     // both or neither: no change
        end
    end

endmodule

`default_nettype wire

/* verilog/key_input_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_input_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en,
    input  logic [`KEY_NUM-1:0]       key_raw,
    output key_event_pkg::key_event_t evt,
    output logic                      evt_valid,
    input  logic                      evt_ready,
    output logic                      overflow
);

    logic [`KEY_NUM-1:0]       key_sync_q;
    logic [`KEY_NUM-1:0]       key_level;
    key_event_pkg::key_event_t evt_in;
    logic                      evt_in_valid;
    logic                      evt_in_ready;

    key_sync u_sync (
        .clk        (clk),
        .rst        (rst),
        .key_raw    (key_raw),
        .key_sync_q (key_sync_q)
    );

    // one filter per key line
    for (genvar k = 0; k < `KEY_NUM; k++) begin : g_deb
        key_debounce u_deb (
            .clk     (clk),
            .rst     (rst),
            .en      (en),
            .key_in  (key_sync_q[k]),
            .key_out (key_level[k])
        );
    end

    key_event_gen u_gen (
        .clk          (clk),
        .rst          (rst),
        .key_level    (key_level),
        .evt_in       (evt_in),
        .evt_in_valid (evt_in_valid),
        .evt_in_ready (evt_in_ready),
        .overflow     (overflow)
    );

    key_event_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_evt    (evt_in),
        .in_valid  (evt_in_valid),
        .in_ready  (evt_in_ready),
        .out_evt   (evt),
        .out_valid (evt_valid),
        .out_ready (evt_ready)
    );

endmodule

`default_nettype wire

/* dv/key_input_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "key_defs.svh"

module key_input_tb;

    localparam int EVT_TIMEOUT  = 200;     // cycles allowed per expected event
    localparam int PULSE_CYCLES = 6;       // well under either threshold

    logic                      clk;
    logic                      rst;
    logic                      en;
    logic [`KEY_NUM-1:0]       key_raw;
    key_event_pkg::key_event_t evt;
    logic                      evt_valid;
    logic                      evt_ready;
    logic                      overflow;

    logic [`KEY_NUM-1:0]       key_drv;    // applied on the next falling edge
    logic                      en_drv;
    logic                      stall;      // consumer holds ready low
    key_event_pkg::key_event_t got_q [$];
    int                        errors;
    int                        tests;
    int                        failed;

    key_input_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .key_raw   (key_raw),
        .evt       (evt),
        .evt_valid (evt_valid),
        .evt_ready (evt_ready),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(`KEY_CLK_PRD_NS / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ready-side model, one clock per call
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(negedge clk);
        key_raw   = key_drv;
        en        = en_drv;
        evt_ready = stall ? 1'b0 : (($urandom % 4) != 0);
        #1;
        if (evt_valid && evt_ready) begin
            got_q.push_back(evt);          // taken on the coming rising edge
        end
    endtask

    task automatic check_event(input key_event_pkg::key_event_t got,
                               input key_event_pkg::key_event_t exp, input string name);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %s key %0d, expected %s key %0d", $time, name,
                     got.kind.name(), got.key_id, exp.kind.name(), exp.key_id);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: overflow is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // short pulses away from the current level, always ending where it started
    task automatic bounce_keys(input logic [`KEY_NUM-1:0] mask);
        int pulses;
        int width;
        pulses = 3 + int'($urandom % 4);
        for (int p = 0; p < pulses; p++) begin
            key_drv = key_drv ^ mask;
            width   = 1 + int'($urandom % 12);  // stays under the low threshold
            repeat (width) next_cycle();
            key_drv = key_drv ^ mask;
            width   = 1 + int'($urandom % 12);
            repeat (width) next_cycle();
        end
    endtask

    // expected events in order, then a quiet window with nothing more
    task automatic collect_events(input string name, input int n_exp,
                                  input logic [31:0] exp_list, input int hold);
        key_event_pkg::key_event_t exp_evt;
        key_event_pkg::key_event_t extra;
        int                        waited;
        for (int i = 0; i < n_exp; i++) begin
            exp_evt = exp_list[4*(n_exp-1-i) +: 4];     // first event is leftmost
            waited  = 0;
            while (got_q.size() == 0 && waited < EVT_TIMEOUT) begin
                next_cycle();
                waited++;
            end
            if (got_q.size() == 0) begin
                $display("%s: timed out after %0d cycles waiting for event %0d of %0d",
                         name, EVT_TIMEOUT, i + 1, n_exp);
                errors++;
                break;
            end
            check_event(got_q.pop_front(), exp_evt, name);
        end
        repeat (hold) next_cycle();
        while (got_q.size() != 0) begin
            extra = got_q.pop_front();
            $display("%s: unexpected %s event for key %0d", name, extra.kind.name(),
                     extra.key_id);
            errors++;
        end
    endtask

    task automatic run_step(input string name, input string act,
                            input logic [`KEY_NUM-1:0] mask, input int hold,
                            input int n_exp, input logic [31:0] exp_list, input logic exp_ovf);
        int err_start;
        err_start = errors;
        if (act == "press") begin
            key_drv = key_drv & ~mask;     // active low
        end else if (act == "release") begin
            key_drv = key_drv | mask;
        end else if (act == "pulse") begin
            key_drv = key_drv & ~mask;     // brief press, then back up
            repeat (PULSE_CYCLES) next_cycle();
            key_drv = key_drv | mask;
        end else if (act == "bounce") begin
            bounce_keys(mask);
        end else if (act == "stall_on") begin
            stall = 1'b1;
        end else if (act == "stall_off") begin
            stall = 1'b0;
        end else if (act == "en_off") begin
            en_drv = 1'b0;
        end else if (act == "en_on") begin
            en_drv = 1'b1;
        end else begin
            $display("%s: unknown action '%s' in the case file", name, act);
            errors++;
        end
        collect_events(name, n_exp, exp_list, hold);
        check_flag(overflow, exp_ovf, name);
        tests++;
        if (errors != err_start) begin
            failed++;
        end
        $display("%s: %s", name, (errors == err_start) ? "ok" : "failed");
    endtask

    initial begin
        int                  fd;
        int                  nf;
        string               line;
        string               name;
        string               act;
        logic [`KEY_NUM-1:0] mask;
        int                  hold;
        int                  n_exp;
        logic [31:0]         exp_list;
        int                  exp_ovf;

        void'($urandom(26));
        errors    = 0;
        tests     = 0;
        failed    = 0;
        rst       = 1'b1;
        en        = 1'b1;
        en_drv    = 1'b1;
        stall     = 1'b0;
        evt_ready = 1'b0;
        key_raw   = {`KEY_NUM{1'b1}};
        key_drv   = {`KEY_NUM{1'b1}};
        repeat (16) @(negedge clk);
        rst = 1'b0;
        next_cycle();
        check_flag(overflow, 1'b0, "reset");

        fd = $fopen("dv/key_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/key_cases.txt for reading");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                nf = $sscanf(line, "%s %h %s %d %d %h %d", name, mask, act, hold,
                             n_exp, exp_list, exp_ovf);
                if (nf == 7 && line.getc(0) != "#") begin
                    run_step(name, act, mask, hold, n_exp, exp_list, exp_ovf != 0);
                end else if (nf > 0 && line.getc(0) != "#") begin
                    $display("malformed line in the case file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
            if (tests == 0) begin
                $display("no test steps were found in the case file");
                errors++;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/key_cases.txt */
# name  keys(hex mask)  action  hold(quiet cycles)  n_events  events(hex)  overflow
# each event nibble is {kind,key_id} with press=0 release=1, first event leftmost
press_k1            02  press      40  1  1       0
release_k1          02  release    40  1  9       0
press_k6            40  press      40  1  6       0
release_k6          40  release    40  1  e       0
bounce_k3_low       08  bounce     60  0  0       0
press_k7            80  press      40  1  7       0
bounce_k7_high      80  bounce     60  0  0       0
release_k7          80  release    40  1  f       0
group_press         2c  press      40  3  235     0
group_release       2c  release    50  3  abd     0
en_off              00  en_off     10  0  0       0
pulse_press_k2      04  press       2  1  2       0
pulse_release_k2    04  release    40  1  a       0
en_on               00  en_on      10  0  0       0
stall_on            00  stall_on    5  0  0       0
stall_press         3f  press      40  0  0       0
stall_release_k4    10  release    45  0  0       1
stall_off           00  stall_off  20  6  0123c5  1
release_rest        2f  release    50  5  89abd   1

/* key_input.f */
+incdir+common
common/key_event_pkg.sv
common/key_ctrl_pkg.sv
verilog/key_sync.sv
debounce/key_debounce.sv
verilog/key_event_gen.sv
verilog/key_event_fifo.sv
verilog/key_input_top.sv
dv/key_input_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := key_input_tb
FILELIST   := key_input.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
